// File: source/sense_pkg.sv
// -------------------
// current sense datapath types.
// widths, sample and result words, configuration.
// -------------------
`default_nettype none

package sense_pkg;

	localparam int in_width   = 13;
	localparam int out_width  = 16;
	// sample width plus growth of rate 32 cubed.
	localparam int acc_width  = 28;
	localparam int rate_bits  = 5;
	localparam int shift_bits = 5;

	typedef struct packed {
		logic                       valid;
		logic signed [in_width-1:0] data;
	} sample_t;

	typedef struct packed {
		logic                        valid;
		logic signed [out_width-1:0] data;
	} result_t;

	typedef struct packed {
		logic                       enable;
		logic [rate_bits-1:0]       rate_m1;
		logic [shift_bits-1:0]      shift;
		logic signed [in_width-1:0] offset;
	} sense_cfg_t;

endpackage

`default_nettype wire

// File: source/apb_pkg.sv
// -------------------
// APB bus types and register map
// of the current sense block.
// -------------------
`default_nettype none

package apb_pkg;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// register offsets.
	localparam logic [7:0] addr_ctrl   = 8'h00;
	localparam logic [7:0] addr_offset = 8'h04;
	localparam logic [7:0] addr_status = 8'h08;
	localparam logic [7:0] addr_result = 8'h0C;

	// field positions.
	localparam int ctrl_enable_bit     = 0;
	localparam int ctrl_rate_lsb       = 8;
	localparam int ctrl_shift_lsb      = 16;
	localparam int offset_lsb          = 0;
	localparam int status_count_lsb    = 0;
	localparam int status_overflow_bit = 8;
	localparam int status_clip_bit     = 9;

endpackage

`default_nettype wire

// File: source/sense_regs.sv
// -------------------
// APB register block for the sense path.
// control, offset, sticky status, result pops.
// -------------------
`timescale 1ns/1ns
`default_nettype none

module sense_regs (
	input  logic                  clk,
	input  logic                  reset,
	input  apb_pkg::apb_req_t     apb_req,
	output apb_pkg::apb_rsp_t     apb_rsp,
	output sense_pkg::sense_cfg_t cfg,
	input  logic                  clip,
	input  sense_pkg::result_t    fifo_head,
	input  logic [3:0]            fifo_count,
	input  logic                  overflow,
	output logic                  pop
);

	logic        access;
	logic        wr_access;
	logic        rd_access;
	logic        addr_hit;
	logic        status_wr;
	logic        clip_sticky;
	logic        overflow_sticky;
	logic [31:0] read_data;

	assign access    = apb_req.psel && apb_req.penable;
	assign wr_access = access && apb_req.pwrite;
	assign rd_access = access && !apb_req.pwrite;
	assign status_wr = wr_access && (apb_req.paddr == apb_pkg::addr_status);

	always_comb begin
		case (apb_req.paddr)
			apb_pkg::addr_ctrl,
			apb_pkg::addr_offset,
			apb_pkg::addr_status,
			apb_pkg::addr_result: addr_hit = 1'b1;
			default:              addr_hit = 1'b0;
		endcase
	end

	// read mux, only meaningful in the access phase.
	always_comb begin
		read_data = '0;
		case (apb_req.paddr)
			apb_pkg::addr_ctrl: begin
				read_data[apb_pkg::ctrl_enable_bit] = cfg.enable;
				read_data[apb_pkg::ctrl_rate_lsb +: sense_pkg::rate_bits] = cfg.rate_m1;
				read_data[apb_pkg::ctrl_shift_lsb +: sense_pkg::shift_bits] = cfg.shift;
			end
			apb_pkg::addr_offset: begin
				read_data[apb_pkg::offset_lsb +: sense_pkg::in_width] = cfg.offset;
			end
			apb_pkg::addr_status: begin
				read_data[apb_pkg::status_count_lsb +: 4] = fifo_count;
				read_data[apb_pkg::status_overflow_bit] = overflow_sticky;
				read_data[apb_pkg::status_clip_bit] = clip_sticky;
			end
			apb_pkg::addr_result: begin
				// empty FIFO reads as zero.
				if (fifo_head.valid) begin
					read_data = {{(32-sense_pkg::out_width){fifo_head.data[sense_pkg::out_width-1]}},
						fifo_head.data};
				end
			end
			default: begin
				read_data = '0;
			end
		endcase
	end

	assign apb_rsp.prdata  = rd_access ? read_data : '0;
	assign apb_rsp.pready  = access;
	assign apb_rsp.pslverr = access && !addr_hit;

	assign pop = rd_access && (apb_req.paddr == apb_pkg::addr_result) && fifo_head.valid;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cfg             <= '0;
			clip_sticky     <= 1'b0;
			overflow_sticky <= 1'b0;
		end else begin
			if (wr_access && (apb_req.paddr == apb_pkg::addr_ctrl)) begin
				cfg.enable  <= apb_req.pwdata[apb_pkg::ctrl_enable_bit];
				cfg.rate_m1 <= apb_req.pwdata[apb_pkg::ctrl_rate_lsb +: sense_pkg::rate_bits];
				cfg.shift   <= apb_req.pwdata[apb_pkg::ctrl_shift_lsb +: sense_pkg::shift_bits];
			end
			if (wr_access && (apb_req.paddr == apb_pkg::addr_offset)) begin
				cfg.offset <= apb_req.pwdata[apb_pkg::offset_lsb +: sense_pkg::in_width];
			end
			// a new event wins over a write-1 clear.
			clip_sticky <= clip ||
				(clip_sticky && !(status_wr && apb_req.pwdata[apb_pkg::status_clip_bit]));
			overflow_sticky <= overflow ||
				(overflow_sticky && !(status_wr && apb_req.pwdata[apb_pkg::status_overflow_bit]));
		end
	end

endmodule

`default_nettype wire

// File: source/sample_conditioner.sv
// -------------------
// sample conditioner.
// offset removal with saturation and clip flag.
// -------------------
`timescale 1ns/1ns
`default_nettype none

module sample_conditioner #(
	parameter int IN_WIDTH = sense_pkg::in_width
) (
	input  logic                  clk,
	input  logic                  reset,
	input  sense_pkg::sense_cfg_t cfg,
	input  sense_pkg::sample_t    sample_in,
	output sense_pkg::sample_t    sample_out,
	output logic                  clip
);

	localparam logic signed [IN_WIDTH-1:0] SAT_MAX = {1'b0, {(IN_WIDTH-1){1'b1}}};
	localparam logic signed [IN_WIDTH-1:0] SAT_MIN = {1'b1, {(IN_WIDTH-1){1'b0}}};

	logic                       take;
	logic signed [IN_WIDTH:0]   diff;
	logic                       saturate;
	logic signed [IN_WIDTH-1:0] limited;
	logic                       out_valid;
	logic signed [IN_WIDTH-1:0] out_data;

	assign take = sample_in.valid && cfg.enable;

	// one guard bit, then check it against the sign.
	assign diff = {sample_in.data[IN_WIDTH-1], sample_in.data} -
		{cfg.offset[IN_WIDTH-1], cfg.offset};
	assign saturate = diff[IN_WIDTH] != diff[IN_WIDTH-1];
	assign limited  = !saturate ? diff[IN_WIDTH-1:0] : (diff[IN_WIDTH] ? SAT_MIN : SAT_MAX);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_valid <= 1'b0;
			clip      <= 1'b0;
		end else begin
			out_valid <= take;
			clip      <= take && saturate;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out_data <= limited;
		end
	end

	assign sample_out.valid = out_valid;
	assign sample_out.data  = out_data;

endmodule

`default_nettype wire

// File: source/cic_decimator.sv
// -------------------
// sinc3 CIC decimator.
// rate and output shift come from the register block.
// -------------------
`timescale 1ns/1ns
`default_nettype none

module cic_decimator #(
	parameter int IN_WIDTH  = sense_pkg::in_width,
	parameter int OUT_WIDTH = sense_pkg::out_width,
	parameter int ACC_WIDTH = sense_pkg::acc_width
) (
	input  logic                  clk,
	input  logic                  reset,
	input  sense_pkg::sense_cfg_t cfg,
	input  sense_pkg::sample_t    sample,
	output sense_pkg::result_t    result
);

	logic signed [ACC_WIDTH-1:0]      sample_ext;
	logic signed [ACC_WIDTH-1:0]      integ1;
	logic signed [ACC_WIDTH-1:0]      integ2;
	logic signed [ACC_WIDTH-1:0]      integ3;
	logic signed [ACC_WIDTH-1:0]      integ1_next;
	logic signed [ACC_WIDTH-1:0]      integ2_next;
	logic signed [ACC_WIDTH-1:0]      integ3_next;
	logic [sense_pkg::rate_bits-1:0]  block_count;
	logic                             block_done;
	logic                             cap_valid;
	logic                             comb1_valid;
	logic                             comb2_valid;
	logic                             out_valid;
	logic signed [ACC_WIDTH-1:0]      cap;
	logic signed [ACC_WIDTH-1:0]      comb1;
	logic signed [ACC_WIDTH-1:0]      comb2;
	logic signed [ACC_WIDTH-1:0]      comb3;
	logic signed [ACC_WIDTH-1:0]      comb3_shifted;
	logic signed [ACC_WIDTH-1:0]      delay1;
	logic signed [ACC_WIDTH-1:0]      delay2;
	logic signed [ACC_WIDTH-1:0]      delay3;
	logic signed [OUT_WIDTH-1:0]      out_data;

	assign sample_ext = {{(ACC_WIDTH-IN_WIDTH){sample.data[IN_WIDTH-1]}}, sample.data};

	// integrator chain is combinational so that the kernel
	// ends on the current sample.
	assign integ1_next = integ1 + sample_ext;
	assign integ2_next = integ2 + integ1_next;
	assign integ3_next = integ3 + integ2_next;

	assign block_done = sample.valid && (block_count == cfg.rate_m1);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			integ1      <= '0;
			integ2      <= '0;
			integ3      <= '0;
			block_count <= '0;
		end else if (!cfg.enable) begin
			integ1      <= '0;
			integ2      <= '0;
			integ3      <= '0;
			block_count <= '0;
		end else if (sample.valid) begin
			integ1 <= integ1_next;
			integ2 <= integ2_next;
			integ3 <= integ3_next;
			block_count <= block_done ? '0 : block_count + 1'b1;
		end
	end

	// comb pipeline, each stage steps on its own valid.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cap_valid   <= 1'b0;
			comb1_valid <= 1'b0;
			comb2_valid <= 1'b0;
			out_valid   <= 1'b0;
			delay1      <= '0;
			delay2      <= '0;
			delay3      <= '0;
		end else if (!cfg.enable) begin
			cap_valid   <= 1'b0;
			comb1_valid <= 1'b0;
			comb2_valid <= 1'b0;
			out_valid   <= 1'b0;
			delay1      <= '0;
			delay2      <= '0;
			delay3      <= '0;
		end else begin
			cap_valid   <= block_done;
			comb1_valid <= cap_valid;
			comb2_valid <= comb1_valid;
			out_valid   <= comb2_valid;
			if (cap_valid) begin
				delay1 <= cap;
			end
			if (comb1_valid) begin
				delay2 <= comb1;
			end
			if (comb2_valid) begin
				delay3 <= comb2;
			end
		end
	end

	assign comb3         = comb2 - delay3;
	assign comb3_shifted = comb3 >>> cfg.shift;

	always_ff @(posedge clk) begin
		if (block_done) begin
			cap <= integ3_next;
		end
		if (cap_valid) begin
			comb1 <= cap - delay1;
		end
		if (comb1_valid) begin
			comb2 <= comb1 - delay2;
		end
		if (comb2_valid) begin
			out_data <= comb3_shifted[OUT_WIDTH-1:0];
		end
	end

	assign result.valid = out_valid;
	assign result.data  = out_data;

endmodule

`default_nettype wire

// File: source/result_fifo.sv
// -------------------
// result FIFO.
// drops new results when full and flags it.
// -------------------
`timescale 1ns/1ns
`default_nettype none

module result_fifo #(
	parameter int OUT_WIDTH  = sense_pkg::out_width,
	parameter int FIFO_DEPTH = 8
) (
	input  logic               clk,
	input  logic               reset,
	input  sense_pkg::result_t push,
	input  logic               pop,
	output sense_pkg::result_t head,
	output logic [3:0]         count,
	output logic               overflow
);

	localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

	logic signed [OUT_WIDTH-1:0] mem [FIFO_DEPTH];
	logic [PTR_WIDTH-1:0]        wr_ptr;
	logic [PTR_WIDTH-1:0]        rd_ptr;
	logic                        empty;
	logic                        full;
	logic                        wr_en;
	logic                        rd_en;

	function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
		return (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty = (count == 4'd0);
	assign full  = (count == 4'(FIFO_DEPTH));
	assign wr_en = push.valid && !full;
	assign rd_en = pop && !empty;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// oldest entries stay, the new one is lost.
			overflow <= push.valid && full;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= push.data;
		end
	end

	assign head.valid = !empty;
	assign head.data  = mem[rd_ptr];

endmodule

`default_nettype wire

// File: source/current_sense_top.sv
// -------------------
// current sense decimation front end.
// conditioner, sinc3 decimator, result FIFO
// and the APB register block.
// -------------------
`timescale 1ns/1ns
`default_nettype none

module current_sense_top #(
	parameter int IN_WIDTH   = sense_pkg::in_width,
	parameter int OUT_WIDTH  = sense_pkg::out_width,
	parameter int ACC_WIDTH  = sense_pkg::acc_width,
	parameter int FIFO_DEPTH = 8
) (
	input  logic               clk,
	input  logic               reset,
	input  apb_pkg::apb_req_t  apb_req,
	output apb_pkg::apb_rsp_t  apb_rsp,
	input  sense_pkg::sample_t sample_in
);

	sense_pkg::sense_cfg_t cfg;
	sense_pkg::sample_t    cond_sample;
	sense_pkg::result_t    cic_result;
	sense_pkg::result_t    fifo_head;
	logic [3:0]            fifo_count;
	logic                  clip;
	logic                  overflow;
	logic                  pop;

	sense_regs u_regs (
		.clk        (clk),
		.reset      (reset),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.cfg        (cfg),
		.clip       (clip),
		.fifo_head  (fifo_head),
		.fifo_count (fifo_count),
		.overflow   (overflow),
		.pop        (pop)
	);

	sample_conditioner #(.IN_WIDTH(IN_WIDTH)) u_conditioner (
		.clk        (clk),
		.reset      (reset),
		.cfg        (cfg),
		.sample_in  (sample_in),
		.sample_out (cond_sample),
		.clip       (clip)
	);

	cic_decimator #(
		.IN_WIDTH  (IN_WIDTH),
		.OUT_WIDTH (OUT_WIDTH),
		.ACC_WIDTH (ACC_WIDTH)
	) u_cic (
		.clk    (clk),
		.reset  (reset),
		.cfg    (cfg),
		.sample (cond_sample),
		.result (cic_result)
	);

	result_fifo #(
		.OUT_WIDTH  (OUT_WIDTH),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk      (clk),
		.reset    (reset),
		.push     (cic_result),
		.pop      (pop),
		.head     (fifo_head),
		.count    (fifo_count),
		.overflow (overflow)
	);

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
// -------------------
// testbench clock.
// 20 ns period.
// -------------------
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
	output logic clk
);

	localparam int half_period = 10;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

endmodule

`default_nettype wire

// File: bench/sense_assertions.sv
// -------------------
// bound assertions on the APB
// response and the FIFO handshake.
// -------------------
`timescale 1ns/1ns
`default_nettype none

module sense_assertions #(
	parameter int DEPTH = 8
) (
	input logic              clk,
	input logic              reset,
	input apb_pkg::apb_req_t apb_req,
	input apb_pkg::apb_rsp_t apb_rsp,
	input logic              pop,
	input logic [3:0]        fifo_count
);

	int fail_count = 0;

	// every setup phase is answered in the next cycle.
	ready_after_setup: assert property (@(posedge clk) disable iff (reset)
		(apb_req.psel && !apb_req.penable) |=> apb_rsp.pready)
	else begin
		fail_count++;
		$error("no pready in the access phase that follows an APB setup phase");
	end

	// a pop takes one entry out, so the count cannot grow behind it.
	pop_drains: assert property (@(posedge clk) disable iff (reset)
		pop |=> (fifo_count <= $past(fifo_count)))
	else begin
		fail_count++;
		$error("FIFO count grew after a pop");
	end

	count_in_range: assert property (@(posedge clk) disable iff (reset)
		fifo_count <= 4'(DEPTH))
	else begin
		fail_count++;
		$error("FIFO count above its depth");
	end

endmodule

bind sense_regs sense_assertions u_assert (
	.clk        (clk),
	.reset      (reset),
	.apb_req    (apb_req),
	.apb_rsp    (apb_rsp),
	.pop        (pop),
	.fifo_count (fifo_count)
);

`default_nettype wire

// File: bench/tb_checker.sv
// -------------------
// sinc3 reference model and checks
// of APB responses and result reads.
// -------------------
`timescale 1ns/1ns
`default_nettype none

module tb_checker #(
	parameter int DEPTH = 8
) (
	input  logic               clk,
	input  logic               reset,
	input  apb_pkg::apb_req_t  apb_req,
	input  apb_pkg::apb_rsp_t  apb_rsp,
	input  sense_pkg::sample_t sample_in,
	input  logic               expect_valid,
	input  logic [31:0]        expect_data,
	input  logic [31:0]        expect_mask,
	input  int                 test_num,
	input  logic               test_done,
	output int                 error_count,
	output int                 check_count
);

	localparam int sat_max = (1 << (sense_pkg::in_width - 1)) - 1;
	localparam int sat_min = -(1 << (sense_pkg::in_width - 1));

	// conditioned samples since the last enable.
	int          history[$];
	// model of the result FIFO contents.
	logic [31:0] expected[$];
	logic        enable;
	int          rate;
	int          shift;
	int          offset;
	int          test_checks;
	int          test_errors;

	function automatic int condition(input int raw);
		int diff;
		diff = raw - offset;
		if (diff > sat_max) return sat_max;
		if (diff < sat_min) return sat_min;
		return diff;
	endfunction

	// three cascaded moving sums of length rate, earlier samples zero.
	function automatic logic [31:0] sinc3_ref(input int block);
		longint                        acc;
		int                            last;
		int                            idx;
		int                            a;
		int                            b;
		int                            c;
		logic [sense_pkg::out_width-1:0] low;
		acc = 0;
		last = block * rate + rate - 1;
		for (a = 0; a < rate; a++) begin
			for (b = 0; b < rate; b++) begin
				for (c = 0; c < rate; c++) begin
					idx = last - a - b - c;
					if (idx >= 0) acc += longint'(history[idx]);
				end
			end
		end
		acc = acc >>> shift;
		low = acc[sense_pkg::out_width-1:0];
		return {{(32-sense_pkg::out_width){low[sense_pkg::out_width-1]}}, low};
	endfunction

	function automatic string reg_name(input logic [7:0] addr);
		case (addr)
			apb_pkg::addr_ctrl:   return "ctrl";
			apb_pkg::addr_offset: return "offset";
			apb_pkg::addr_status: return "status";
			apb_pkg::addr_result: return "result";
			default:              return "unmapped";
		endcase
	endfunction

	function automatic string test_name(input int num);
		case (num)
			1:       return "registers";
			2:       return "dc_input";
			3:       return "random_samples";
			4:       return "offset_clip";
			5:       return "reconfigure";
			6:       return "overflow";
			default: return "unknown";
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		test_checks++;
		if (exp !== act) begin
			error_count++;
			test_errors++;
			$display("ERR %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic accept_sample(input logic signed [sense_pkg::in_width-1:0] data);
		history.push_back(condition(int'(data)));
		// a full FIFO keeps its oldest results.
		if ((history.size() % rate == 0) && (expected.size() < DEPTH)) begin
			expected.push_back(sinc3_ref(history.size() / rate - 1));
		end
	endtask

	task automatic check_access();
		logic        mapped;
		logic [31:0] pw;
		string       name;
		mapped = apb_req.paddr inside {apb_pkg::addr_ctrl, apb_pkg::addr_offset,
			apb_pkg::addr_status, apb_pkg::addr_result};
		pw = apb_req.pwdata;
		name = $sformatf("prdata(%s)", reg_name(apb_req.paddr));
		compare("pready", 32'h1, {31'b0, apb_rsp.pready});
		compare("pslverr", {31'b0, !mapped}, {31'b0, apb_rsp.pslverr});
		if (apb_req.pwrite) begin
			if (apb_req.paddr == apb_pkg::addr_ctrl) begin
				// a rising enable restarts the history.
				if (pw[apb_pkg::ctrl_enable_bit] && !enable) history.delete();
				enable = pw[apb_pkg::ctrl_enable_bit];
				rate = int'(pw[apb_pkg::ctrl_rate_lsb +: sense_pkg::rate_bits]) + 1;
				shift = int'(pw[apb_pkg::ctrl_shift_lsb +: sense_pkg::shift_bits]);
			end else if (apb_req.paddr == apb_pkg::addr_offset) begin
				offset = int'($signed(pw[apb_pkg::offset_lsb +: sense_pkg::in_width]));
			end
		end else if (apb_req.paddr == apb_pkg::addr_result) begin
			if (expected.size() > 0) compare(name, expected.pop_front(), apb_rsp.prdata);
			else compare(name, 32'h0, apb_rsp.prdata);
		end else if (expect_valid) begin
			compare(name, expect_data & expect_mask, apb_rsp.prdata & expect_mask);
		end
	endtask

	// mid cycle, where bench inputs and APB read data are settled.
	always @(negedge clk) begin
		if (reset) begin
			history.delete();
			expected.delete();
			enable = 1'b0;
			rate = 1;
			shift = 0;
			offset = 0;
			error_count = 0;
			check_count = 0;
			test_checks = 0;
			test_errors = 0;
		end else begin
			// the sample sees the enable from before this cycle's write.
			if (sample_in.valid && enable) accept_sample(sample_in.data);
			if (apb_req.psel && apb_req.penable) check_access();
			if (test_done) begin
				$display("test %0d %s done: %0d checks, %0d errors",
					test_num, test_name(test_num), test_checks, test_errors);
				test_checks = 0;
				test_errors = 0;
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/tb_top.sv
// -------------------
// testbench top for the current sense front end.
// reset, APB traffic, sample stimulus, watchdog.
// -------------------
`timescale 1ns/1ns
`default_nettype none

module tb_top;

	localparam int fifo_depth     = 8;
	localparam int dc_samples     = 64;
	localparam int random_samples = 360;
	localparam int clip_samples   = 96;
	localparam int reconf_samples = 42;
	localparam int ovf_samples    = 40;
	localparam int total_samples  = dc_samples + random_samples + clip_samples +
		reconf_samples + ovf_samples;
	localparam int timeout_cycles = total_samples * 3 + 2000;

	logic               clk;
	logic               reset;
	apb_pkg::apb_req_t  apb_req;
	apb_pkg::apb_rsp_t  apb_rsp;
	sense_pkg::sample_t sample_in;
	logic               expect_valid;
	logic [31:0]        expect_data;
	logic [31:0]        expect_mask;
	int                 test_num;
	logic               test_done;
	int                 error_count;
	int                 check_count;
	int                 assert_fails;
	int                 seed;

	tb_clock u_clock (
		.clk (clk)
	);

	current_sense_top #(.FIFO_DEPTH(fifo_depth)) dut (
		.clk       (clk),
		.reset     (reset),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.sample_in (sample_in)
	);

	tb_checker #(.DEPTH(fifo_depth)) u_checker (
		.clk          (clk),
		.reset        (reset),
		.apb_req      (apb_req),
		.apb_rsp      (apb_rsp),
		.sample_in    (sample_in),
		.expect_valid (expect_valid),
		.expect_data  (expect_data),
		.expect_mask  (expect_mask),
		.test_num     (test_num),
		.test_done    (test_done),
		.error_count  (error_count),
		.check_count  (check_count)
	);

	function automatic logic [31:0] ctrl_word(input logic en, input int rate_m1, input int shift);
		logic [31:0] word;
		word = '0;
		word[apb_pkg::ctrl_enable_bit] = en;
		word[apb_pkg::ctrl_rate_lsb +: sense_pkg::rate_bits] = rate_m1[sense_pkg::rate_bits-1:0];
		word[apb_pkg::ctrl_shift_lsb +: sense_pkg::shift_bits] = shift[sense_pkg::shift_bits-1:0];
		return word;
	endfunction

	// setup phase, access phase, then wait for pready.
	task automatic apb_access(input logic [7:0] addr, input logic write, input logic [31:0] data);
		@(posedge clk);
		#2;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = data;
		@(posedge clk);
		#2;
		apb_req.penable = 1'b1;
		@(posedge clk);
		while (!apb_rsp.pready) begin
			@(posedge clk);
		end
		#2;
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		apb_access(addr, 1'b1, data);
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic [31:0] value,
		input logic [31:0] mask);
		expect_valid = (mask != 32'h0);
		expect_data  = value;
		expect_mask  = mask;
		apb_access(addr, 1'b0, 32'h0);
		expect_valid = 1'b0;
	endtask

	task automatic read_results(input int count);
		repeat (count) apb_read(apb_pkg::addr_result, 32'h0, 32'h0);
	endtask

	task automatic set_config(input int rate_m1, input int shift, input int offset);
		apb_write(apb_pkg::addr_ctrl, ctrl_word(1'b0, rate_m1, shift));
		apb_write(apb_pkg::addr_offset, offset);
		apb_write(apb_pkg::addr_ctrl, ctrl_word(1'b1, rate_m1, shift));
	endtask

	task automatic drive_samples(input int count, input logic use_random, input int level);
		logic [31:0] rnd;
		repeat (count) begin
			@(posedge clk);
			#2;
			rnd = $random(seed);
			sample_in.valid = 1'b1;
			if (use_random) sample_in.data = rnd[sense_pkg::in_width-1:0];
			else sample_in.data = level[sense_pkg::in_width-1:0];
		end
		@(posedge clk);
		#2;
		sample_in = '0;
		// results reach the FIFO 5 cycles after the last sample.
		repeat (20) @(posedge clk);
	endtask

	task automatic finish_test();
		@(posedge clk);
		#2;
		test_done = 1'b1;
		@(posedge clk);
		#2;
		test_done = 1'b0;
	endtask

	initial begin
		seed = 32'h9985db45;
		apb_req = '0;
		sample_in = '0;
		expect_valid = 1'b0;
		expect_data = 32'h0;
		expect_mask = 32'h0;
		test_num = 0;
		test_done = 1'b0;
		reset = 1'b1;
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;

		test_num = 1;
		apb_read(apb_pkg::addr_status, 32'h0, 32'hffff_ffff);
		apb_write(apb_pkg::addr_ctrl, 32'hffff_1f1e);
		apb_read(apb_pkg::addr_ctrl, 32'h001f_1f00, 32'hffff_ffff);
		apb_write(apb_pkg::addr_offset, 32'hffff_1abc);
		apb_read(apb_pkg::addr_offset, 32'h0000_1abc, 32'hffff_ffff);
		apb_write(apb_pkg::addr_status, 32'h0000_0300);
		apb_read(apb_pkg::addr_status, 32'h0, 32'hffff_ffff);
		// unmapped and read-only offsets leave the registers alone.
		apb_write(8'h14, 32'h0000_0001);
		apb_write(apb_pkg::addr_result, 32'h0000_0001);
		apb_read(8'h10, 32'h0, 32'h0);
		apb_read(apb_pkg::addr_ctrl, 32'h001f_1f00, 32'hffff_ffff);
		finish_test();

		test_num = 2;
		set_config(7, 9, 0);
		drive_samples(dc_samples, 1'b0, 1000);
		read_results(dc_samples / 8);
		finish_test();

		test_num = 3;
		set_config(29, 15, 0);
		repeat (3) begin
			drive_samples(random_samples / 3, 1'b1, 0);
			read_results(4);
		end
		finish_test();

		test_num = 4;
		set_config(15, 12, 1500);
		drive_samples(clip_samples, 1'b1, 0);
		read_results(clip_samples / 16);
		apb_read(apb_pkg::addr_status, 32'h0000_0200, 32'h0000_0200);
		apb_write(apb_pkg::addr_status, 32'h0000_0200);
		apb_read(apb_pkg::addr_status, 32'h0, 32'h0000_0200);
		finish_test();

		test_num = 5;
		apb_write(apb_pkg::addr_ctrl, ctrl_word(1'b0, 15, 12));
		// dropped while disabled.
		drive_samples(10, 1'b1, 0);
		apb_write(apb_pkg::addr_ctrl, ctrl_word(1'b0, 3, 6));
		apb_write(apb_pkg::addr_ctrl, ctrl_word(1'b1, 3, 6));
		drive_samples(reconf_samples - 10, 1'b1, 0);
		read_results(8);
		finish_test();

		test_num = 6;
		set_config(3, 6, 0);
		drive_samples(ovf_samples, 1'b1, 0);
		apb_read(apb_pkg::addr_status, 32'h0000_0108, 32'h0000_01ff);
		read_results(9);
		apb_write(apb_pkg::addr_status, 32'h0000_0100);
		apb_read(apb_pkg::addr_status, 32'h0, 32'h0000_01ff);
		finish_test();

		repeat (5) @(posedge clk);
		assert_fails = dut.u_regs.u_assert.fail_count;
		$display("summary: %0d checks, %0d errors, %0d assertion failures",
			check_count, error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// watchdog sized from the total sample count.
	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
source/sense_pkg.sv
source/apb_pkg.sv
source/sense_regs.sv
source/sample_conditioner.sv
source/cic_decimator.sv
source/result_fifo.sv
source/current_sense_top.sv
bench/tb_clock.sv
bench/sense_assertions.sv
bench/tb_checker.sv
bench/tb_top.sv

// File: Makefile
SIM      ?= verilator
TOP      ?= tb_top
FLIST    ?= flist.f
FLAGS    ?= --binary --timing --assert -j 0
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
RUN_ARGS ?= +verilator+error+limit+1000
PASS_MSG := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
